// ==== Bender.yml ====
package:
  name: i3c_target_frontend

sources:
  - files:
      - common/i3c_pkg.sv
      - common/ctrl_pkg.sv
      - src/bus_monitor/bus_monitor.sv
      - src/configuration.sv
      - src/target/target_fsm.sv
      - src/controller.sv

  - target: test
    files:
      - testbench/tb_controller.sv

// ==== common/ctrl_pkg.sv ====
// Target control definitions
// CSR register map, target configuration and FSM states

package ctrl_pkg;

  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned StaAddrWidth = 7;

  // Field positions inside the CSR words
  localparam int unsigned CtrlEnableBit   = 0;
  localparam int unsigned StaAddrValidBit = 7;

  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_STA_ADDR = 2'd1,
    REG_T_HD_DAT = 2'd2
  } csr_addr_e;

  typedef struct packed {
    logic                    enable;
    logic                    sta_addr_valid;
    logic [StaAddrWidth-1:0] sta_addr;
  } target_cfg_t;

  typedef enum logic [2:0] {
    T_IDLE,
    T_ADDR,
    T_ADDR_ACK,
    T_WR_DATA,
    T_DATA_ACK,
    T_IGNORE
  } target_state_e;

endpackage

// ==== common/i3c_pkg.sv ====
// I3C/I2C bus-level types
// Shared by the bus monitor, the target FSM and the top level

package i3c_pkg;

  // One synchronized bus line
  typedef struct packed {
    logic value;
    logic pos_edge;
    logic neg_edge;
  } line_state_t;

  // Bus conditions, one-cycle pulses
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_events_t;

  typedef struct packed {
    line_state_t scl;
    line_state_t sda;
    bus_events_t events;
  } bus_state_t;

  // Address byte as received, RnW in bit 0
  typedef struct packed {
    logic [7:0] addr;
    logic       valid;
  } addr_report_t;

  // Write data byte
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } rx_byte_t;

endpackage

// ==== src/bus_monitor/bus_monitor.sv ====
// Bus state monitor
// Synchronizes SCL and SDA, flags line edges and detects
// START, repeated START and STOP conditions

`timescale 1ns/1ns

module bus_monitor (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                scl_i,
  input  logic                sda_i,
  output i3c_pkg::bus_state_t state_o
);
  import i3c_pkg::*;

  logic [1:0]  scl_sync;
  logic [1:0]  sda_sync;
  logic        scl_hist;
  logic        sda_hist;
  logic        busy_q;
  logic        start_det;
  logic        stop_det;
  line_state_t scl_now;
  line_state_t sda_now;
  bus_state_t  state_q;

  function automatic line_state_t track_line(logic cur, logic prev);
    line_state_t ls;
    ls.value    = cur;
    ls.pos_edge = cur & ~prev;
    ls.neg_edge = ~cur & prev;
    return ls;
  endfunction

  // Lines idle high
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_hist <= 1'b1;
      sda_hist <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_i};
      sda_sync <= {sda_sync[0], sda_i};
      scl_hist <= scl_sync[1];
      sda_hist <= sda_sync[1];
    end
  end

  assign scl_now = track_line(scl_sync[1], scl_hist);
  assign sda_now = track_line(sda_sync[1], sda_hist);

  // SDA moving while SCL stays high
  assign start_det = sda_now.neg_edge & scl_now.value & scl_hist;
  assign stop_det  = sda_now.pos_edge & scl_now.value & scl_hist;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q                <= 1'b0;
      state_q               <= '0;
      state_q.scl.value     <= 1'b1;
      state_q.sda.value     <= 1'b1;
    end else begin
      if (start_det) begin
        busy_q <= 1'b1;
      end else if (stop_det) begin
        busy_q <= 1'b0;
      end
      state_q.scl           <= scl_now;
      state_q.sda           <= sda_now;
      state_q.events.start  <= start_det & ~busy_q;
      state_q.events.rstart <= start_det & busy_q;
      state_q.events.stop   <= stop_det;
    end
  end

  assign state_o = state_q;

  a_events_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0(state_o.events)
  );

endmodule

// ==== src/configuration.sv ====
// Target configuration registers
// Enable, static address and SDA hold time behind a simple CSR port

`timescale 1ns/1ns

module configuration #(
  parameter int unsigned TimerWidth = 20
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              csr_we_i,
  input  ctrl_pkg::csr_addr_e               csr_addr_i,
  input  logic [ctrl_pkg::CsrDataWidth-1:0] csr_wdata_i,
  output logic [ctrl_pkg::CsrDataWidth-1:0] csr_rdata_o,
  output ctrl_pkg::target_cfg_t             cfg_o,
  output logic [TimerWidth-1:0]             t_hd_dat_o
);
  import ctrl_pkg::*;

  target_cfg_t           cfg_q;
  logic [TimerWidth-1:0] t_hd_dat_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q      <= '0;
      t_hd_dat_q <= '0;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        REG_CTRL: begin
          cfg_q.enable <= csr_wdata_i[CtrlEnableBit];
        end
        REG_STA_ADDR: begin
          cfg_q.sta_addr_valid <= csr_wdata_i[StaAddrValidBit];
          cfg_q.sta_addr       <= csr_wdata_i[StaAddrWidth-1:0];
        end
        REG_T_HD_DAT: begin
          // Upper bits beyond the counter width are dropped
          t_hd_dat_q <= csr_wdata_i[TimerWidth-1:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      REG_CTRL: begin
        csr_rdata_o[CtrlEnableBit] = cfg_q.enable;
      end
      REG_STA_ADDR: begin
        csr_rdata_o[StaAddrValidBit]    = cfg_q.sta_addr_valid;
        csr_rdata_o[StaAddrWidth-1:0]   = cfg_q.sta_addr;
      end
      REG_T_HD_DAT: begin
        csr_rdata_o[TimerWidth-1:0] = t_hd_dat_q;
      end
      default: ;
    endcase
  end

  assign cfg_o      = cfg_q;
  assign t_hd_dat_o = t_hd_dat_q;

endmodule

// ==== src/controller.sv ====
// I3C/I2C target front end top level
// Bus monitor, CSR configuration and static-address write target

`timescale 1ns/1ns

module controller #(
  parameter int unsigned TimerWidth = 20
) (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Bus pins, sda_o high releases the line
  input  logic                              scl_i,
  input  logic                              sda_i,
  output logic                              sda_o,

  input  logic                              csr_we_i,
  input  ctrl_pkg::csr_addr_e               csr_addr_i,
  input  logic [ctrl_pkg::CsrDataWidth-1:0] csr_wdata_i,
  output logic [ctrl_pkg::CsrDataWidth-1:0] csr_rdata_o,

  output i3c_pkg::bus_events_t              bus_events_o,
  output logic                              bus_scl_posedge_o,
  output i3c_pkg::addr_report_t             bus_addr_o,
  output i3c_pkg::rx_byte_t                 rx_o,
  output logic                              xfer_in_progress_o
);
  import i3c_pkg::*;
  import ctrl_pkg::*;

  bus_state_t            bus;
  target_cfg_t           cfg;
  logic [TimerWidth-1:0] t_hd_dat;

  bus_monitor xbus_monitor (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .state_o (bus)
  );

  assign bus_events_o      = bus.events;
  assign bus_scl_posedge_o = bus.scl.pos_edge;

  configuration #(
    .TimerWidth (TimerWidth)
  ) xconfiguration (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .t_hd_dat_o  (t_hd_dat)
  );

  target_fsm #(
    .TimerWidth (TimerWidth)
  ) xtarget_fsm (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .bus_i              (bus),
    .cfg_i              (cfg),
    .t_hd_dat_i         (t_hd_dat),
    .sda_o              (sda_o),
    .addr_o             (bus_addr_o),
    .rx_o               (rx_o),
    .xfer_in_progress_o (xfer_in_progress_o)
  );

endmodule

// ==== src/target/target_fsm.sv ====
// Static-address write target
// Matches the address byte, ACKs writes to the static address and
// receives the following data bytes, ACKing each one

`timescale 1ns/1ns

module target_fsm #(
  parameter int unsigned TimerWidth = 20
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  i3c_pkg::bus_state_t   bus_i,
  input  ctrl_pkg::target_cfg_t cfg_i,
  input  logic [TimerWidth-1:0] t_hd_dat_i,
  output logic                  sda_o,
  output i3c_pkg::addr_report_t addr_o,
  output i3c_pkg::rx_byte_t     rx_o,
  output logic                  xfer_in_progress_o
);
  import i3c_pkg::*;
  import ctrl_pkg::*;

  target_state_e         state_q;
  logic [7:0]            shift_q;
  logic [2:0]            bit_cnt_q;
  logic [7:0]            byte_in;
  logic                  byte_done;
  logic                  addr_match;
  logic                  in_ack;
  logic                  hold_busy_q;
  logic [TimerWidth-1:0] hold_cnt_q;
  logic [TimerWidth-1:0] hold_elapsed;
  logic                  hold_fire;
  logic                  sda_q;
  logic                  xfer_q;
  addr_report_t          addr_q;
  rx_byte_t              rx_q;

  // MSB first, current bit taken from the live SDA value
  assign byte_in   = {shift_q[6:0], bus_i.sda.value};
  assign byte_done = bus_i.scl.pos_edge && (bit_cnt_q == 3'd7);

  assign addr_match = cfg_i.enable && cfg_i.sta_addr_valid &&
                      (byte_in[7:1] == cfg_i.sta_addr) && !byte_in[0];

  assign in_ack = (state_q == T_ADDR_ACK) || (state_q == T_DATA_ACK);

  // Cycles since the SCL negedge that opened the hold window
  assign hold_elapsed = bus_i.scl.neg_edge ? '0 : hold_cnt_q;
  assign hold_fire    = in_ack && (bus_i.scl.neg_edge || hold_busy_q) &&
                        (({1'b0, hold_elapsed} + 1'b1) >= {1'b0, t_hd_dat_i});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_busy_q <= 1'b0;
      hold_cnt_q  <= '0;
    end else if (!in_ack || hold_fire) begin
      hold_busy_q <= 1'b0;
      hold_cnt_q  <= '0;
    end else if (bus_i.scl.neg_edge) begin
      hold_busy_q <= 1'b1;
      hold_cnt_q  <= TimerWidth'(1);
    end else if (hold_busy_q) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.scl.pos_edge) begin
      shift_q <= byte_in;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= T_IDLE;
      bit_cnt_q    <= '0;
      sda_q        <= 1'b1;
      xfer_q       <= 1'b0;
      addr_q.valid <= 1'b0;
      rx_q.valid   <= 1'b0;
    end else begin
      addr_q.valid <= 1'b0;
      rx_q.valid   <= 1'b0;
      if (bus_i.events.stop) begin
        state_q   <= T_IDLE;
        bit_cnt_q <= '0;
        sda_q     <= 1'b1;
        xfer_q    <= 1'b0;
      end else if (bus_i.events.start || bus_i.events.rstart) begin
        state_q   <= T_ADDR;
        bit_cnt_q <= '0;
        sda_q     <= 1'b1;
      end else begin
        case (state_q)
          T_ADDR: begin
            if (bus_i.scl.pos_edge) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done && addr_match) begin
              addr_q.addr  <= byte_in;
              addr_q.valid <= 1'b1;
              xfer_q       <= 1'b1;
              state_q      <= T_ADDR_ACK;
            end else if (byte_done) begin
              // Reads and foreign addresses are left unanswered
              state_q <= T_IGNORE;
            end
          end
          T_WR_DATA: begin
            if (bus_i.scl.pos_edge) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done) begin
              rx_q.data  <= byte_in;
              rx_q.valid <= 1'b1;
              state_q    <= T_DATA_ACK;
            end
          end
          T_ADDR_ACK, T_DATA_ACK: begin
            // First hold window drives the ACK, second one releases it
            if (hold_fire && sda_q) begin
              sda_q <= 1'b0;
            end else if (hold_fire) begin
              sda_q   <= 1'b1;
              state_q <= T_WR_DATA;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign sda_o              = sda_q;
  assign addr_o             = addr_q;
  assign rx_o               = rx_q;
  assign xfer_in_progress_o = xfer_q;

  a_sda_low_in_ack: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !sda_o |-> (state_q inside {T_ADDR_ACK, T_DATA_ACK})
  );

endmodule

// ==== testbench/tb_controller.sv ====
// Testbench for the I3C/I2C target front end
// Bit-bangs SCL/SDA from a transaction table and checks CSR access,
// bus events, header ACKs and received write data

`timescale 1ns/1ns

module tb_controller;
  import i3c_pkg::*;
  import ctrl_pkg::*;

  localparam int          Half    = 20;
  localparam int          HoldDat = 4;
  localparam int          Timeout = 200;
  localparam logic [6:0]  StaAddr = 7'h2A;
  localparam logic [6:0]  Decoy   = 7'h51;

  typedef struct packed {
    logic [1:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
  } csr_case_t;

  typedef struct packed {
    logic       en;
    logic       sta_valid;
    logic [6:0] addr;
    logic       rnw;
    logic       rstart;
    logic [2:0] nbytes;
    logic       exp_ack;
  } xfer_t;

  logic                    clk_i;
  logic                    rst_i;
  logic                    scl_i;
  logic                    sda_drv;
  logic                    sda_i;
  logic                    sda_o;
  logic                    csr_we_i;
  csr_addr_e               csr_addr_i;
  logic [CsrDataWidth-1:0] csr_wdata_i;
  logic [CsrDataWidth-1:0] csr_rdata_o;
  bus_events_t             bus_events_o;
  logic                    bus_scl_posedge_o;
  addr_report_t            bus_addr_o;
  rx_byte_t                rx_o;
  logic                    xfer_in_progress_o;

  csr_case_t  csr_cases [4];
  xfer_t      xfers [9];
  int         test_id;
  int         test_errs;
  int         ok_cnt;
  int         bad_cnt;
  int         start_cnt;
  int         rstart_cnt;
  int         stop_cnt;
  int         rise_cnt;
  int         addr_cnt;
  int         sda_low_cnt;
  logic [7:0] addr_seen;
  logic [7:0] rx_seen [$];
  logic [7:0] sent [$];

  // Open-drain line, a target output of X counts as released
  assign sda_i = sda_drv & (sda_o !== 1'b0);

  controller #(
    .TimerWidth (20)
  ) dut0 (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .scl_i              (scl_i),
    .sda_i              (sda_i),
    .sda_o              (sda_o),
    .csr_we_i           (csr_we_i),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_rdata_o        (csr_rdata_o),
    .bus_events_o       (bus_events_o),
    .bus_scl_posedge_o  (bus_scl_posedge_o),
    .bus_addr_o         (bus_addr_o),
    .rx_o               (rx_o),
    .xfer_in_progress_o (xfer_in_progress_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Pulses last one full cycle, so the falling edge sees each once
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (bus_events_o.start) start_cnt++;
      if (bus_events_o.rstart) rstart_cnt++;
      if (bus_events_o.stop) stop_cnt++;
      if (bus_scl_posedge_o) rise_cnt++;
      if (!sda_o) sda_low_cnt++;
      if (bus_addr_o.valid) begin
        addr_cnt++;
        addr_seen = bus_addr_o.addr;
      end
      if (rx_o.valid) rx_seen.push_back(rx_o.data);
    end
  end

  task automatic cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic report_fail(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("FAIL test %0d: %s expected 0x%0h got 0x%0h", test_id, sig, exp, got);
    test_errs++;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      ok_cnt++;
      $display("test %0d ok", test_id);
    end else begin
      bad_cnt++;
      $display("test %0d failed with %0d errors", test_id, test_errs);
    end
    test_id++;
    test_errs = 0;
  endtask

  task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = csr_addr_e'(addr);
    csr_wdata_i = data;
    cycles(1);
    csr_we_i    = 1'b0;
  endtask

  // which = 0 waits for START, 1 waits for STOP
  task automatic wait_bus_event(input int which, input int target);
    int n;
    n = 0;
    while (((which == 0) ? start_cnt : stop_cnt) < target && n < Timeout) begin
      @(posedge clk_i);
      n++;
    end
    #1;
    if (((which == 0) ? start_cnt : stop_cnt) < target) begin
      $display("test %0d: no %s seen on the bus within %0d clocks", test_id,
               (which == 0) ? "START" : "STOP", Timeout);
      test_errs++;
    end
  endtask

  task automatic bus_start();
    cycles(Half);
    sda_drv = 1'b0;
    cycles(Half);
    scl_i = 1'b0;
  endtask

  task automatic bus_rstart();
    cycles(Half / 2);
    sda_drv = 1'b1;
    cycles(Half / 2);
    scl_i = 1'b1;
    cycles(Half);
    sda_drv = 1'b0;
    cycles(Half);
    scl_i = 1'b0;
  endtask

  task automatic bus_stop();
    cycles(Half / 2);
    sda_drv = 1'b0;
    cycles(Half / 2);
    scl_i = 1'b1;
    cycles(Half);
    sda_drv = 1'b1;
    cycles(Half);
  endtask

  // Eight data bits, then a released ninth bit sampled mid-high
  task automatic send_byte(input logic [7:0] b, output logic ack_sda, output logic xfer);
    for (int i = 7; i >= -1; i--) begin
      cycles(Half / 2);
      sda_drv = (i >= 0) ? b[i] : 1'b1;
      cycles(Half / 2);
      scl_i = 1'b1;
      cycles(Half / 2);
      if (i < 0) begin
        ack_sda = sda_o;
        xfer    = xfer_in_progress_o;
      end
      cycles(Half / 2);
      scl_i = 1'b0;
    end
  endtask

  task automatic run_xfer(input xfer_t x);
    logic       ack;
    logic       xfer;
    logic [7:0] b;
    csr_write(REG_CTRL, {31'd0, x.en});
    csr_write(REG_STA_ADDR, {24'd0, x.sta_valid, StaAddr});
    {start_cnt, rstart_cnt, stop_cnt, rise_cnt, addr_cnt, sda_low_cnt} = '0;
    rx_seen.delete();
    sent.delete();
    bus_start();
    wait_bus_event(0, 1);
    if (x.rstart) begin
      send_byte({Decoy, 1'b0}, ack, xfer);
      bus_rstart();
    end
    send_byte({x.addr, x.rnw}, ack, xfer);
    if (ack !== !x.exp_ack) report_fail("sda_o (header ACK)", !x.exp_ack, ack);
    if (xfer !== x.exp_ack) report_fail("xfer_in_progress_o", x.exp_ack, xfer);
    for (int k = 0; k < x.nbytes; k++) begin
      b = 8'($urandom);
      sent.push_back(b);
      send_byte(b, ack, xfer);
      if (x.exp_ack && ack !== 1'b0) report_fail("sda_o (data ACK)", 0, ack);
      if (x.exp_ack && xfer !== 1'b1) report_fail("xfer_in_progress_o", 1, xfer);
    end
    bus_stop();
    wait_bus_event(1, 1);
    cycles(2);
    if (xfer_in_progress_o !== 1'b0) report_fail("xfer_in_progress_o", 0, xfer_in_progress_o);
    if (start_cnt != 1) report_fail("bus_events_o.start count", 1, start_cnt);
    if (rstart_cnt != x.rstart) report_fail("bus_events_o.rstart count", x.rstart, rstart_cnt);
    if (stop_cnt != 1) report_fail("bus_events_o.stop count", 1, stop_cnt);
    // Nine pulses per byte, plus the rise before STOP and before a repeated START
    if (rise_cnt != 9 * (1 + x.rstart + x.nbytes) + 1 + x.rstart) begin
      report_fail("bus_scl_posedge_o count", 9 * (1 + x.rstart + x.nbytes) + 1 + x.rstart,
                  rise_cnt);
    end
    if (addr_cnt != x.exp_ack) report_fail("bus_addr_o.valid count", x.exp_ack, addr_cnt);
    if (x.exp_ack && addr_seen !== {x.addr, x.rnw}) begin
      report_fail("bus_addr_o.addr", {x.addr, x.rnw}, addr_seen);
    end
    if (rx_seen.size() != (x.exp_ack ? sent.size() : 0)) begin
      report_fail("rx_o.valid count", x.exp_ack ? sent.size() : 0, rx_seen.size());
    end else if (x.exp_ack) begin
      for (int k = 0; k < sent.size(); k++) begin
        if (rx_seen[k] !== sent[k]) report_fail("rx_o.data", sent[k], rx_seen[k]);
      end
    end
    if (!x.exp_ack && sda_low_cnt != 0) report_fail("sda_o low cycles", 0, sda_low_cnt);
    cycles(Half);
  endtask

  initial begin
    void'($urandom(77));
    rst_i       = 1'b1;
    scl_i       = 1'b1;
    sda_drv     = 1'b1;
    csr_we_i    = 1'b0;
    csr_addr_i  = REG_CTRL;
    csr_wdata_i = '0;
    {test_id, test_errs, ok_cnt, bad_cnt} = '0;
    {start_cnt, rstart_cnt, stop_cnt, rise_cnt, addr_cnt, sda_low_cnt} = '0;
    addr_seen = '0;

    // Read values follow the register field layout
    csr_cases[0] = '{2'd0, 32'hFFFF_FFFF, 32'h0000_0001};
    csr_cases[1] = '{2'd1, 32'hFFFF_FFAA, 32'h0000_00AA};
    csr_cases[2] = '{2'd2, 32'hFFFF_FFFF, 32'h000F_FFFF};
    csr_cases[3] = '{2'd3, 32'hFFFF_FFFF, 32'h0000_0000};

    // en, sta_valid, addr, rnw, rstart, nbytes, exp_ack
    xfers[0] = '{1'b1, 1'b1, StaAddr, 1'b0, 1'b0, 3'd2, 1'b1};
    xfers[1] = '{1'b1, 1'b1, StaAddr, 1'b0, 1'b0, 3'd0, 1'b1};
    xfers[2] = '{1'b1, 1'b1, StaAddr, 1'b0, 1'b1, 3'd3, 1'b1};
    xfers[3] = '{1'b1, 1'b1, 7'h15,   1'b0, 1'b0, 3'd2, 1'b0};
    xfers[4] = '{1'b1, 1'b1, StaAddr, 1'b1, 1'b0, 3'd1, 1'b0};
    xfers[5] = '{1'b1, 1'b0, StaAddr, 1'b0, 1'b0, 3'd2, 1'b0};
    xfers[6] = '{1'b0, 1'b1, StaAddr, 1'b0, 1'b0, 3'd2, 1'b0};
    xfers[7] = '{1'b1, 1'b1, StaAddr, 1'b0, 1'b1, 3'd4, 1'b1};
    xfers[8] = '{1'b1, 1'b1, StaAddr, 1'b1, 1'b1, 3'd0, 1'b0};

    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    cycles(2);

    foreach (csr_cases[i]) begin
      csr_write(csr_cases[i].addr, csr_cases[i].wdata);
      csr_addr_i = csr_addr_e'(csr_cases[i].addr);
      cycles(1);
      if (csr_rdata_o !== csr_cases[i].rdata) begin
        report_fail("csr_rdata_o", csr_cases[i].rdata, csr_rdata_o);
      end
      finish_test();
    end

    csr_write(REG_T_HD_DAT, HoldDat);
    foreach (xfers[i]) begin
      run_xfer(xfers[i]);
      finish_test();
    end

    $display("tests: %0d ok, %0d failed", ok_cnt, bad_cnt);
    if (bad_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
common/i3c_pkg.sv
common/ctrl_pkg.sv
src/bus_monitor/bus_monitor.sv
src/configuration.sv
src/target/target_fsm.sv
src/controller.sv
testbench/tb_controller.sv
